// File: include/lsu_settings.svh
/* fixed 32-bit datapath with 4 byte lanes, little-endian
   the word step is the distance to the second part of a split access */
`ifndef LSU_SETTINGS_SVH
`define LSU_SETTINGS_SVH

`define LSU_ADDR_W 32      // byte address width
`define LSU_DATA_W 32      // bus and core data width
`define LSU_BE_W 4         // one enable per byte lane

// address step between the two parts of a split access
`define LSU_WORD_BYTES 4

`endif

// File: hdl/lsu_core_pkg.sv
/* core-side types of the load/store unit
   the core holds a command stable until the unit reports it done */
`default_nettype none

`include "lsu_settings.svh"

package lsu_core_pkg;

  // access size opcodes, 2'b11 is not a legal size
  typedef enum logic [1:0] {
    LSU_WORD = 2'b00,
    LSU_HALF = 2'b01,
    LSU_BYTE = 2'b10
  } lsu_size_e;

  typedef struct packed {
    logic                   we;        // store when set
    lsu_size_e              size;
    logic                   sign_ext;  // loads only
    logic [`LSU_ADDR_W-1:0] addr;      // byte address, any alignment
    logic [`LSU_DATA_W-1:0] wdata;     // store data, right aligned
  } lsu_cmd_t;

  typedef struct packed {
    logic                   valid;        // one pulse per request
    logic                   rdata_valid;  // load finished without error
    logic [`LSU_DATA_W-1:0] rdata;
    logic                   load_err;
    logic                   store_err;
  } lsu_resp_t;

  // sequencer states
  typedef enum logic [2:0] {
    IDLE, WAIT_GNT_MIS, WAIT_RVALID_MIS, WAIT_GNT,
    WAIT_RVALID_MIS_GNTS_DONE
  } lsu_state_e;

endpackage

`default_nettype wire

// File: hdl/lsu_bus_pkg.sv
/* memory bus types, request/grant with in-order rvalid responses
   addresses on this bus are always word aligned */
`default_nettype none

`include "lsu_settings.svh"

package lsu_bus_pkg;

  typedef struct packed {
    logic [`LSU_ADDR_W-1:0] addr;   // word address, low bits zero
    logic                   we;
    logic [`LSU_BE_W-1:0]   be;     // byte lane enables
    logic [`LSU_DATA_W-1:0] wdata;  // already rotated to its lanes
  } bus_cmd_t;

  typedef struct packed {
    logic                   rvalid;  // one per granted part
    logic                   err;     // qualified by rvalid
    logic [`LSU_DATA_W-1:0] rdata;
  } bus_rsp_t;

endpackage

`default_nettype wire

// File: hdl/lsu_ctrl_fsm.sv
/* sequences one or two bus parts per core request
   a new request is only issued once the previous response is due this cycle
   or has already arrived, so the data path never sees two accesses mixed */
`timescale 1ns/1ps
`default_nettype none

module lsu_ctrl_fsm import lsu_core_pkg::*; (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic lsu_req_i,       // core request, held until done
  input  logic split_i,         // access needs two bus parts
  input  logic bus_gnt_i,
  input  logic bus_rvalid_i,
  input  logic bus_err_i,
  output logic bus_req_o,
  output logic second_part_o,   // selects the upper word
  output logic ctrl_update_o,   // capture access control
  output logic rdata_update_o,  // capture first response word
  output logic req_done_o,
  output logic resp_valid_o,
  output logic resp_err_o,
  output logic busy_o
);

  lsu_state_e state_q, state_d;
  logic       second_q, second_d;  // second part still to be granted
  logic       err_q, err_d;        // error seen on the first part
  logic       pend_q, pend_d;      // final response still outstanding
  logic       first_part;          // request on the bus is a split first part
  logic       can_issue;

  // old response must be gone, or arrive now
  assign can_issue = ~pend_q | bus_rvalid_i;

  //////////////////////////////
  // next state
  always_comb begin
    state_d        = state_q;
    second_d       = second_q;
    err_d          = err_q;
    bus_req_o      = 1'b0;
    ctrl_update_o  = 1'b0;
    rdata_update_o = 1'b0;
    first_part     = 1'b0;

    unique case (state_q)
      IDLE: begin
        if (lsu_req_i && can_issue) begin
          bus_req_o  = 1'b1;
          err_d      = 1'b0;      // fresh access
          first_part = split_i;
          if (bus_gnt_i) begin
            ctrl_update_o = 1'b1;
            second_d      = split_i;
            state_d       = split_i ? WAIT_RVALID_MIS : IDLE;
          end else begin
            state_d       = split_i ? WAIT_GNT_MIS : WAIT_GNT;
          end
        end
      end

      WAIT_GNT_MIS: begin
        bus_req_o  = 1'b1;
        first_part = 1'b1;
        if (bus_gnt_i) begin
          ctrl_update_o = 1'b1;
          second_d      = 1'b1;
          state_d       = WAIT_RVALID_MIS;
        end
      end

      WAIT_RVALID_MIS: begin
        bus_req_o = 1'b1;               // second part goes out right away
        if (bus_rvalid_i) begin
          err_d          = bus_err_i;   // remember first part status
          rdata_update_o = 1'b1;
          second_d       = ~bus_gnt_i;
          state_d        = bus_gnt_i ? IDLE : WAIT_GNT;
        end else if (bus_gnt_i) begin
          // both parts granted, first data still due
          second_d = 1'b0;
          state_d  = WAIT_RVALID_MIS_GNTS_DONE;
        end
      end

      WAIT_GNT: begin
        bus_req_o = 1'b1;  // aligned part or second part, held by second_q
        if (bus_gnt_i) begin
          ctrl_update_o = 1'b1;
          second_d      = 1'b0;
          state_d       = IDLE;
        end
      end

      WAIT_RVALID_MIS_GNTS_DONE: begin
        if (bus_rvalid_i) begin
          err_d          = bus_err_i;
          rdata_update_o = 1'b1;
          state_d        = IDLE;    // second rvalid ends it in IDLE
        end
      end

      default: state_d = IDLE;
    endcase
  end

  // done once the last part is granted
  assign req_done_o = bus_req_o & bus_gnt_i & ~first_part;

  // set by the last grant, cleared by the final rvalid
  assign pend_d = req_done_o | (pend_q & ~resp_valid_o);

  //////////////////////////////
  // state registers
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q  <= IDLE;
      second_q <= 1'b0;
      err_q    <= 1'b0;
      pend_q   <= 1'b0;
    end else begin
      state_q  <= state_d;
      second_q <= second_d;
      err_q    <= err_d;
      pend_q   <= pend_d;
    end
  end

  assign second_part_o = second_q;
  assign resp_valid_o  = (state_q == IDLE) & bus_rvalid_i;  // final part only
  assign resp_err_o    = err_q | bus_err_i;                 // either part failed
  assign busy_o        = (state_q != IDLE) | pend_q;

endmodule

`default_nettype wire

// File: hdl/lsu_req_gen.sv
/* purely combinational, the core command must be stable while requested
   the second part always targets the next word, with the upper bytes */
`timescale 1ns/1ps
`default_nettype none

`include "lsu_settings.svh"

module lsu_req_gen import lsu_core_pkg::*; import lsu_bus_pkg::*; (
  input  lsu_cmd_t cmd_i,
  input  logic     second_part_i,  // from the sequencer
  output bus_cmd_t bus_cmd_o,
  output logic     split_o,
  output logic [1:0] offset_o
);

  logic [1:0]             offset;
  logic [`LSU_ADDR_W-1:0] addr_aligned;
  logic [`LSU_BE_W-1:0]   be;
  logic [`LSU_DATA_W-1:0] wdata_rot;

  assign offset       = cmd_i.addr[1:0];
  assign addr_aligned = {cmd_i.addr[`LSU_ADDR_W-1:2], 2'b00};

  //////////////////////////////
  // byte enables
  always_comb begin
    unique case (cmd_i.size)
      LSU_WORD: begin
        if (!second_part_i) begin
          be = 4'b1111 << offset;     // 1111 1110 1100 1000
        end else begin
          be = ~(4'b1111 << offset);  // 0001 0011 0111 for offsets 1..3
        end
      end
      LSU_HALF: begin
        if (!second_part_i) begin
          be = 4'b0011 << offset;     // offset 3 keeps only lane 3
        end else begin
          be = 4'b0001;               // spill byte of a half at offset 3
        end
      end
      LSU_BYTE: be = 4'b0001 << offset;
      default:  be = 4'b1111;
    endcase
  end

  //////////////////////////////
  // store data rotation
  always_comb begin
    unique case (offset)  // rotate left by the byte offset
      2'b00:   wdata_rot = cmd_i.wdata;
      2'b01:   wdata_rot = {cmd_i.wdata[23:0], cmd_i.wdata[31:24]};
      2'b10:   wdata_rot = {cmd_i.wdata[15:0], cmd_i.wdata[31:16]};
      default: wdata_rot = {cmd_i.wdata[7:0],  cmd_i.wdata[31:8]};
    endcase
  end

  // misaligned word, or half crossing into the next word
  assign split_o = ((cmd_i.size == LSU_WORD) && (offset != 2'b00)) ||
                   ((cmd_i.size == LSU_HALF) && (offset == 2'b11));

  assign bus_cmd_o.addr  = second_part_i ? addr_aligned + `LSU_ADDR_W'(`LSU_WORD_BYTES)
                                         : addr_aligned;
  assign bus_cmd_o.we    = cmd_i.we;
  assign bus_cmd_o.be    = be;
  assign bus_cmd_o.wdata = wdata_rot;
  assign offset_o        = offset;

endmodule

`default_nettype wire

// File: hdl/lsu_rdata_align.sv
/* rebuilds load data from one or two bus words and extends it
   access control is captured at grant, so the core may move on afterwards
   error flags and rdata valid only mean something with the valid pulse */
`timescale 1ns/1ps
`default_nettype none

module lsu_rdata_align import lsu_core_pkg::*; import lsu_bus_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  lsu_cmd_t   cmd_i,
  input  logic [1:0] offset_i,
  input  logic       ctrl_update_i,   // grant of a part
  input  logic       rdata_update_i,  // first rvalid of a split access
  input  bus_rsp_t   bus_rsp_i,
  input  logic       resp_valid_i,
  input  logic       resp_err_i,      // combined error of both parts
  output lsu_resp_t  resp_o
);

  logic [1:0]  offset_q;
  lsu_size_e   size_q;
  logic        sign_ext_q;
  logic        we_q;
  logic [31:8] rdata_q;     // upper bytes of the first word
  logic [31:0] rdata;
  logic [31:0] word_ext;
  logic [15:0] half_sel;
  logic [7:0]  byte_sel;
  logic [31:0] rdata_ext;

  assign rdata = bus_rsp_i.rdata;

  //////////////////////////////
  // captured state
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      offset_q   <= 2'b00;
      size_q     <= LSU_WORD;
      sign_ext_q <= 1'b0;
      we_q       <= 1'b0;
    end else if (ctrl_update_i) begin
      offset_q   <= offset_i;
      size_q     <= cmd_i.size;
      sign_ext_q <= cmd_i.sign_ext;
      we_q       <= cmd_i.we;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rdata_update_i) rdata_q <= rdata[31:8];  // lane 0 never needed later
  end

  //////////////////////////////
  // realignment
  always_comb begin
    unique case (offset_q)  // low bytes from the first word, rest from the second
      2'b00:   word_ext = rdata;
      2'b01:   word_ext = {rdata[7:0],  rdata_q[31:8]};
      2'b10:   word_ext = {rdata[15:0], rdata_q[31:16]};
      default: word_ext = {rdata[23:0], rdata_q[31:24]};
    endcase
  end

  always_comb begin
    unique case (offset_q)
      2'b00:   half_sel = rdata[15:0];
      2'b01:   half_sel = rdata[23:8];
      2'b10:   half_sel = rdata[31:16];
      default: half_sel = {rdata[7:0], rdata_q[31:24]};  // crosses the word
    endcase
  end

  assign byte_sel = rdata[{offset_q, 3'b000} +: 8];

  always_comb begin
    unique case (size_q)  // extension by the captured sign flag
      LSU_HALF: rdata_ext = {{16{sign_ext_q & half_sel[15]}}, half_sel};
      LSU_BYTE: rdata_ext = {{24{sign_ext_q & byte_sel[7]}}, byte_sel};
      default:  rdata_ext = word_ext;
    endcase
  end

  assign resp_o.valid       = resp_valid_i;
  assign resp_o.rdata_valid = resp_valid_i & ~resp_err_i & ~we_q;
  assign resp_o.rdata       = rdata_ext;
  assign resp_o.load_err    = resp_valid_i & resp_err_i & ~we_q;
  assign resp_o.store_err   = resp_valid_i & resp_err_i &  we_q;

endmodule

`default_nettype wire

// File: hdl/load_store_unit.sv
/* top level of the load/store unit
   at most one request is sequenced at a time, two bus parts may be in flight */
`timescale 1ns/1ps
`default_nettype none

module load_store_unit import lsu_core_pkg::*; import lsu_bus_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      core_req_i,
  input  lsu_cmd_t  core_cmd_i,
  input  logic      bus_gnt_i,
  input  bus_rsp_t  bus_rsp_i,
  output logic      req_done_o,
  output lsu_resp_t resp_o,
  output logic      busy_o,
  output logic      bus_req_o,
  output bus_cmd_t  bus_cmd_o
);

  logic       split;
  logic       second_part;
  logic       ctrl_update;
  logic       rdata_update;
  logic       resp_valid;
  logic       resp_err;
  logic [1:0] offset;  // byte offset of the access

  lsu_ctrl_fsm u_lsu_ctrl_fsm (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .lsu_req_i      (core_req_i),
    .split_i        (split),
    .bus_gnt_i      (bus_gnt_i),
    .bus_rvalid_i   (bus_rsp_i.rvalid),
    .bus_err_i      (bus_rsp_i.err),
    .bus_req_o      (bus_req_o),
    .second_part_o  (second_part),
    .ctrl_update_o  (ctrl_update),
    .rdata_update_o (rdata_update),
    .req_done_o     (req_done_o),
    .resp_valid_o   (resp_valid),
    .resp_err_o     (resp_err),
    .busy_o         (busy_o)
  );

  lsu_req_gen u_lsu_req_gen (
    .cmd_i         (core_cmd_i),
    .second_part_i (second_part),
    .bus_cmd_o     (bus_cmd_o),
    .split_o       (split),
    .offset_o      (offset)
  );

  lsu_rdata_align u_lsu_rdata_align (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .cmd_i          (core_cmd_i),
    .offset_i       (offset),
    .ctrl_update_i  (ctrl_update),
    .rdata_update_i (rdata_update),
    .bus_rsp_i      (bus_rsp_i),
    .resp_valid_i   (resp_valid),
    .resp_err_i     (resp_err),
    .resp_o         (resp_o)
  );

endmodule

`default_nettype wire

// File: test/load_store_unit_properties.sv
/* bus protocol checks bound into the top level
   split parts are tracked from the grants and the core command */
`timescale 1ns/1ps
`default_nettype none

module load_store_unit_properties import lsu_core_pkg::*; import lsu_bus_pkg::*; (
  input logic      clk_i,
  input logic      rst_ni,
  input lsu_cmd_t  core_cmd_i,
  input logic      bus_gnt_i,
  input logic      bus_req_i,
  input bus_cmd_t  bus_cmd_i,
  input logic      req_done_i,
  input logic      busy_i,
  input lsu_resp_t resp_i
);

  logic        upper_q;       // lower part of a split access was granted
  logic [31:0] first_addr_q;  // word address of the last granted part
  logic        split;         // current access touches two words
  logic [3:0]  be_exp;

  // lanes an access covers in its lower or upper word
  function automatic logic [3:0] lanes(input logic [1:0] off, input lsu_size_e size,
                                       input logic upper);
    int         n;
    logic [3:0] m;
    n = (size == LSU_WORD) ? 4 : (size == LSU_HALF) ? 2 : 1;
    m = '0;
    for (int i = 0; i < n; i++) begin
      if ((off + i > 3) == upper) m[(off + i) % 4] = 1'b1;
    end
    return m;
  endfunction

  assign split  = |lanes(core_cmd_i.addr[1:0], core_cmd_i.size, 1'b1);
  assign be_exp = lanes(core_cmd_i.addr[1:0], core_cmd_i.size, upper_q);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      upper_q      <= 1'b0;
      first_addr_q <= '0;
    end else if (bus_req_i && bus_gnt_i) begin
      upper_q      <= split && !upper_q;  // upper word comes next
      first_addr_q <= bus_cmd_i.addr;
    end
  end

  // everything quiet while reset is held
  reset_quiet: assert property (@(posedge clk_i)
    !rst_ni |-> !bus_req_i && !req_done_i && !busy_i && !resp_i.valid &&
                !resp_i.rdata_valid && !resp_i.load_err && !resp_i.store_err)
    else $error("outputs active during reset");

  // request held with a frozen command until granted
  cmd_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    bus_req_i && !bus_gnt_i |=> bus_req_i && $stable(bus_cmd_i))
    else $error("bus command changed before grant");

  addr_aligned: assert property (@(posedge clk_i) disable iff (!rst_ni)
    bus_req_i |-> bus_cmd_i.addr[1:0] == 2'b00)
    else $error("bus address not word aligned");

  // upper part goes to the word after the granted lower part
  second_addr: assert property (@(posedge clk_i) disable iff (!rst_ni)
    bus_req_i && upper_q |-> bus_cmd_i.addr == first_addr_q + 32'd4)
    else $error("second part address is not first word plus four");

  // enables cover exactly the access bytes in the addressed word
  lane_enables: assert property (@(posedge clk_i) disable iff (!rst_ni)
    bus_req_i |-> bus_cmd_i.be == be_exp)
    else $error("byte enables do not match the bytes of the access");

  // done comes with the grant of the last part only
  done_last: assert property (@(posedge clk_i) disable iff (!rst_ni)
    req_done_i == (bus_req_i && bus_gnt_i && (!split || upper_q)))
    else $error("request done not aligned with the last grant");

endmodule

bind load_store_unit load_store_unit_properties u_load_store_unit_properties (
  .clk_i         (clk_i),
  .rst_ni        (rst_ni),
  .core_cmd_i    (core_cmd_i),
  .bus_gnt_i     (bus_gnt_i),
  .bus_req_i     (bus_req_o),
  .bus_cmd_i     (bus_cmd_o),
  .req_done_i    (req_done_o),
  .busy_i        (busy_o),
  .resp_i        (resp_o)
);

`default_nettype wire

// File: test/load_store_unit_tb.sv
/* 64-byte memory model with random grants and 1..3 cycle in-order responses
   word addresses in the error table fail every part that touches them */
`timescale 1ns/1ps
`default_nettype none

module load_store_unit_tb import lsu_core_pkg::*; import lsu_bus_pkg::*; ();

  localparam int NUM_OPS = 75;            // requests issued over all tests
  localparam logic [31:0] SEED = 32'hda6a_6090;

  typedef struct {
    logic        we;
    logic        err;
    logic [31:0] data;
  } exp_t;

  typedef struct {
    int          due;   // cycle the rvalid goes out
    logic        err;
    logic [31:0] data;
  } mem_rsp_t;

  logic      clk_i, rst_ni, core_req_i, bus_gnt_i;
  lsu_cmd_t  core_cmd_i;
  bus_rsp_t  bus_rsp_i;
  logic      req_done_o, busy_o, bus_req_o;
  lsu_resp_t resp_o;
  bus_cmd_t  bus_cmd_o;

  logic [7:0]  mem [64];      // bus side model
  logic [7:0]  ref_mem [64];  // expected contents, updated at accept
  logic [31:0] err_tab [2] = '{32'h28, 32'h34};
  exp_t        exp_q [$];
  mem_rsp_t    rsp_q [$];
  int          cyc = 0, last_due = 0;
  int          n_req = 0, n_resp = 0, errors = 0;

  load_store_unit u_load_store_unit (.*);

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  function automatic logic is_err_word(input logic [31:0] a);
    foreach (err_tab[i]) if (err_tab[i] == {a[31:2], 2'b00}) return 1'b1;
    return 1'b0;
  endfunction

  //////////////////////////////
  // memory model
  always @(posedge clk_i) begin
    mem_rsp_t   r;
    int         dly;
    logic [5:0] wa;
    cyc = cyc + 1;
    bus_gnt_i <= rst_ni && ($urandom_range(0, 99) < 55);  // random back-pressure
    if (rst_ni && bus_req_o && bus_gnt_i) begin
      wa     = {bus_cmd_o.addr[5:2], 2'b00};
      r.err  = is_err_word(bus_cmd_o.addr);
      r.data = {mem[wa+3], mem[wa+2], mem[wa+1], mem[wa]};
      if (bus_cmd_o.we && !r.err) begin
        for (int i = 0; i < 4; i++) begin
          if (bus_cmd_o.be[i]) mem[wa+i] = bus_cmd_o.wdata[8*i +: 8];
        end
      end
      dly      = $urandom_range(0, 2);
      r.due    = (cyc + dly > last_due) ? cyc + dly : last_due + 1;  // keep order
      last_due = r.due;
      rsp_q.push_back(r);
    end
    if (rsp_q.size() != 0 && rsp_q[0].due == cyc) begin
      bus_rsp_i <= '{rvalid: 1'b1, err: rsp_q[0].err, rdata: rsp_q[0].data};
      void'(rsp_q.pop_front());
    end else begin
      bus_rsp_i <= '0;
    end
  end

  //////////////////////////////
  // response checks
  always @(posedge clk_i) begin
    exp_t e;
    if (rst_ni && resp_o.valid) begin
      n_resp++;
      if (exp_q.size() == 0) begin
        $display("response at %0t without an accepted request", $time);
        errors++;
      end else begin
        e = exp_q.pop_front();
        if (e.err) begin
          err_chk: assert (resp_o.load_err == !e.we && resp_o.store_err == e.we &&
                           !resp_o.rdata_valid)
          else begin
            $display("[FAIL] %0t resp_o.load_err/store_err exp %0b/%0b got %0b/%0b",
                     $time, !e.we, e.we, resp_o.load_err, resp_o.store_err);
            errors++;
          end
        end else if (!e.we) begin
          load_chk: assert (resp_o.rdata_valid && resp_o.rdata == e.data && !resp_o.load_err)
          else begin
            $display("[FAIL] %0t resp_o.rdata exp %08h got %08h (rdata_valid %0b)",
                     $time, e.data, resp_o.rdata, resp_o.rdata_valid);
            errors++;
          end
        end else begin
          store_chk: assert (!resp_o.rdata_valid && !resp_o.load_err && !resp_o.store_err)
          else begin
            $display("[FAIL] %0t resp_o flags exp 000 got %0b%0b%0b", $time,
                     resp_o.rdata_valid, resp_o.load_err, resp_o.store_err);
            errors++;
          end
        end
      end
    end
  end

  // expected value comes from the reference bytes at accept time
  task automatic do_op(input logic we, input lsu_size_e size, input logic sext,
                       input logic [31:0] addr, input logic [31:0] wdata);
    exp_t        e;
    int          n;
    logic        split;
    logic [31:0] v;
    logic [31:0] b;
    n       = (size == LSU_WORD) ? 4 : (size == LSU_HALF) ? 2 : 1;
    split   = (addr[1:0] + n - 1) > 3;  // crosses into the next word
    e.we    = we;
    e.err   = is_err_word(addr) || (split && is_err_word(addr + 32'd4));
    v       = '0;
    for (int i = 0; i < n; i++) begin
      b = addr + i;
      v[8*i +: 8] = ref_mem[b[5:0]];
    end
    if (sext && v[8*n-1]) v = v | (32'hffff_ffff << (8*n));
    e.data  = v;
    core_req_i <= 1'b1;
    core_cmd_i <= '{we: we, size: size, sign_ext: sext, addr: addr, wdata: wdata};
    do @(posedge clk_i); while (!req_done_o);
    exp_q.push_back(e);
    n_req++;
    if (we) begin
      for (int i = 0; i < n; i++) begin
        b = addr + i;
        if (!is_err_word(b)) ref_mem[b[5:0]] = wdata[8*i +: 8];
      end
    end
  endtask

  task automatic end_test(input string name);
    core_req_i <= 1'b0;
    while (exp_q.size() != 0 || busy_o) @(posedge clk_i);
    $display("test %s finished, errors so far %0d", name, errors);
  endtask

  //////////////////////////////
  // stimulus
  initial begin
    lsu_size_e   sz;
    logic [31:0] ad;
    void'($urandom(SEED));
    rst_ni     = 1'b0;
    core_req_i = 1'b0;
    core_cmd_i = '0;
    bus_gnt_i  = 1'b0;
    bus_rsp_i  = '0;
    for (int i = 0; i < 64; i++) begin
      mem[i]     = 8'(i * 8'h1d) ^ 8'ha5;  // every address bit matters
      ref_mem[i] = 8'(i * 8'h1d) ^ 8'ha5;
    end
    repeat (8) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(posedge clk_i);

    for (int k = 0; k < 7; k++) begin  // word, two halves, four bytes
      sz = (k == 0) ? LSU_WORD : (k < 3) ? LSU_HALF : LSU_BYTE;
      ad = (k == 0) ? 32'h0 : (k < 3) ? 32'h4 + 2 * (k - 1) : 32'h8 + (k - 3);
      do_op(1'b1, sz, 1'b0, ad, $urandom() | 32'h8080_8080);
      do_op(1'b0, sz, 1'b0, ad, '0);
      do_op(1'b0, sz, 1'b1, ad, '0);
    end
    end_test("aligned");

    for (int k = 1; k < 4; k++) begin
      do_op(1'b1, LSU_WORD, 1'b0, 32'h10 + k * 4 + k, $urandom());
      do_op(1'b0, LSU_WORD, 1'b0, 32'h10 + k * 4 + k, '0);
    end
    do_op(1'b1, LSU_HALF, 1'b0, 32'h1f, 32'h0000_81c3);
    do_op(1'b0, LSU_HALF, 1'b1, 32'h1f, '0);
    end_test("split");

    do_op(1'b1, LSU_WORD, 1'b0, 32'h26, $urandom());  // error on second part
    do_op(1'b0, LSU_WORD, 1'b0, 32'h26, '0);
    do_op(1'b1, LSU_HALF, 1'b0, 32'h2b, $urandom());  // error on first part
    do_op(1'b0, LSU_HALF, 1'b1, 32'h2b, '0);
    do_op(1'b1, LSU_BYTE, 1'b0, 32'h34, $urandom());
    do_op(1'b0, LSU_BYTE, 1'b1, 32'h35, '0);
    end_test("bus_error");

    for (int k = 0; k < 40; k++) begin  // back to back, mixed
      sz = lsu_size_e'($urandom_range(0, 2));
      do_op(1'($urandom()), sz, 1'($urandom()), $urandom_range(0, 27), $urandom());
    end
    end_test("random");

    cnt_chk: assert (n_req == n_resp)
    else begin
      $display("%0d responses for %0d accepted requests", n_resp, n_req);
      errors++;
    end
    $display("requests %0d, responses %0d, errors %0d", n_req, n_resp, errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

  initial begin
    #(NUM_OPS * 200 + 100);
    $display("watchdog expired before all tests finished");
    $display("STATUS: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// File: load_store_unit.f
+incdir+include
hdl/lsu_core_pkg.sv
hdl/lsu_bus_pkg.sv
hdl/lsu_ctrl_fsm.sv
hdl/lsu_req_gen.sv
hdl/lsu_rdata_align.sv
hdl/load_store_unit.sv
test/load_store_unit_properties.sv
test/load_store_unit_tb.sv
